//--- common/scan_config.svh
// Scan converter constants

`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Control word field positions
`define SC_POWERON_BIT        0
`define SC_ISL_RESET_N_BIT    1
`define SC_HDMIRX_RESET_N_BIT 2
`define SC_CAPTURE_SEL_BIT    7
`define SC_FRAMELOCK_BIT      14

// OSD palette, black, blue, yellow, white
`define OSD_COLOR_0 24'h000000
`define OSD_COLOR_1 24'h0000ff
`define OSD_COLOR_2 24'hffff00
`define OSD_COLOR_3 24'hffffff

// 24 on the board, short here for simulation
`define RESYNC_LED_WIDTH 8

// Transmitter crosstalk workaround, 1 clears red bit 0
`define TX_R0_MASK 1'b1

`endif

//--- common/scan_pkg.sv
// Scan converter shared types

`default_nettype none

package scan_pkg;

    // One colour channel
    typedef logic [7:0] color_t;

    // Red in the top byte, blue in the bottom
    typedef logic [23:0] pixel_t;

    typedef logic [15:0] sys_ctrl_t;

    // Index into the four-entry OSD palette
    typedef logic [1:0] osd_color_t;

    typedef logic [5:0] btn_t;

    // Blue in bit 0, red in bit 2
    typedef logic [2:0] led_t;

    typedef logic [15:0] status_t;

endpackage

`default_nettype wire

//--- source/sys_ctrl_regs.sv
// System control word and status

`timescale 1ns/10ps
`default_nettype none

`include "scan_config.svh"

module sys_ctrl_regs import scan_pkg::*; (
    input  logic      pclk_out,
    input  logic      po_reset_n,
    input  logic      ctrl_wr_i,
    input  sys_ctrl_t ctrl_wdata_i,
    input  btn_t      btn_sync_i,
    input  logic      ir_sync_i,
    input  logic      led_active_i,
    output logic      sys_poweron_o,
    output logic      isl_reset_n_o,
    output logic      hdmirx_reset_n_o,
    output logic      capture_sel_o,
    output logic      framelock_o,
    output status_t   status_o
);

    sys_ctrl_t ctrl_word;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_word <= '0;
        end else if (ctrl_wr_i) begin
            ctrl_word <= ctrl_wdata_i;
        end
    end

    assign sys_poweron_o    = ctrl_word[`SC_POWERON_BIT];
    assign isl_reset_n_o    = ctrl_word[`SC_ISL_RESET_N_BIT];
    assign hdmirx_reset_n_o = ctrl_word[`SC_HDMIRX_RESET_N_BIT];
    assign capture_sel_o    = ctrl_word[`SC_CAPTURE_SEL_BIT];
    assign framelock_o      = ctrl_word[`SC_FRAMELOCK_BIT];

    // Snapshot matches the synchronizers' idle state after reset
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            status_o <= {8'h00, 1'b0, 1'b1, {6{1'b1}}};
        end else begin
            status_o <= {ctrl_word[7:0], led_active_i, ir_sync_i, btn_sync_i};
        end
    end

    // A write shows up on every field one edge later
    a_field_decode: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        ctrl_wr_i |=> (sys_poweron_o == $past(ctrl_wdata_i[`SC_POWERON_BIT]))
            && (capture_sel_o == $past(ctrl_wdata_i[`SC_CAPTURE_SEL_BIT]))
            && (framelock_o == $past(ctrl_wdata_i[`SC_FRAMELOCK_BIT]))
    );

endmodule

`default_nettype wire

//--- source/input_sync.sv
// Front-panel and strobe synchronizers

`timescale 1ns/10ps
`default_nettype none

module input_sync import scan_pkg::*; (
    input  logic pclk_out,
    input  logic po_reset_n,
    input  btn_t btn_i,
    input  logic ir_rx_i,
    input  logic resync_strobe_i,
    output btn_t btn_sync_o,
    output logic ir_sync_o,
    output logic resync_sync_o
);

    btn_t btn_meta;
    logic ir_meta;
    logic resync_meta;

    // Buttons and IR idle high
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_meta      <= '1;
            btn_sync_o    <= '1;
            ir_meta       <= 1'b1;
            ir_sync_o     <= 1'b1;
            resync_meta   <= 1'b0;
            resync_sync_o <= 1'b0;
        end else begin
            btn_meta      <= btn_i;
            btn_sync_o    <= btn_meta;
            ir_meta       <= ir_rx_i;
            ir_sync_o     <= ir_meta;
            resync_meta   <= resync_strobe_i;
            resync_sync_o <= resync_meta;
        end
    end

endmodule

`default_nettype wire

//--- source/status_led.sv
// Status LEDs and resync stretcher

`timescale 1ns/10ps
`default_nettype none

`include "scan_config.svh"

module status_led import scan_pkg::*; (
    input  logic pclk_out,
    input  logic po_reset_n,
    input  logic sys_poweron_i,
    input  logic framelock_i,
    input  logic ir_sync_i,
    input  logic resync_sync_i,
    output led_t led_o,
    output logic led_active_o
);

    logic [`RESYNC_LED_WIDTH-1:0] resync_led_ctr;
    logic resync_prev;
    logic resync_rise;

    assign resync_rise = resync_sync_i & ~resync_prev;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_prev    <= 1'b0;
            resync_led_ctr <= '0;
        end else begin
            resync_prev <= resync_sync_i;
            if (sys_poweron_i) begin
                if (resync_rise) begin
                    resync_led_ctr <= '1;
                end else if (resync_led_ctr != '0) begin
                    resync_led_ctr <= resync_led_ctr - 1'b1;
                end
            end else begin
                // Free-running for the standby blink
                resync_led_ctr <= resync_led_ctr - 1'b1;
            end
        end
    end

    assign led_active_o = (resync_led_ctr != '0);

    // IR lit while the line is low
    assign led_o = sys_poweron_i ?
        {framelock_i, ~ir_sync_i, led_active_o} :
        {2'b00, ~resync_led_ctr[`RESYNC_LED_WIDTH-1]};

    // Drained counter holds at zero while powered
    a_no_wrap_on: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        (sys_poweron_i && resync_led_ctr == '0 && !resync_rise) |=> resync_led_ctr == '0
    );

endmodule

`default_nettype wire

//--- video/capture_mux.sv
// Capture source select

`timescale 1ns/10ps
`default_nettype none

module capture_mux import scan_pkg::*; (
    input  logic   pclk_out,
    input  logic   po_reset_n,
    input  logic   capture_sel_i,
    input  pixel_t isl_pixel_i,
    input  pixel_t hdmirx_pixel_i,
    input  logic   isl_hsync_i,
    input  logic   isl_vsync_i,
    input  logic   isl_de_i,
    input  logic   hdmirx_hsync_i,
    input  logic   hdmirx_vsync_i,
    input  logic   hdmirx_de_i,
    output pixel_t capt_pixel_o,
    output logic   capt_hsync_o,
    output logic   capt_vsync_o,
    output logic   capt_de_o
);

    // High picks the HDMI receiver
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            capt_pixel_o <= '0;
            capt_hsync_o <= 1'b0;
            capt_vsync_o <= 1'b0;
            capt_de_o    <= 1'b0;
        end else if (capture_sel_i) begin
            capt_pixel_o <= hdmirx_pixel_i;
            capt_hsync_o <= hdmirx_hsync_i;
            capt_vsync_o <= hdmirx_vsync_i;
            capt_de_o    <= hdmirx_de_i;
        end else begin
            capt_pixel_o <= isl_pixel_i;
            capt_hsync_o <= isl_hsync_i;
            capt_vsync_o <= isl_vsync_i;
            capt_de_o    <= isl_de_i;
        end
    end

endmodule

`default_nettype wire

//--- video/osd_output.sv
// OSD overlay and HDMI transmit stage

`timescale 1ns/10ps
`default_nettype none

`include "scan_config.svh"

module osd_output import scan_pkg::*; (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  pixel_t     pixel_i,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       de_i,
    input  logic       osd_enable_i,
    input  osd_color_t osd_color_i,
    output color_t     tx_r_o,
    output color_t     tx_g_o,
    output color_t     tx_b_o,
    output logic       tx_hsync_o,
    output logic       tx_vsync_o,
    output logic       tx_de_o
);

    pixel_t pixel_out;
    pixel_t palette_pixel;
    logic   hsync_out;
    logic   vsync_out;
    logic   de_out;

    always_comb begin
        case (osd_color_i)
            2'd0:    palette_pixel = `OSD_COLOR_0;
            2'd1:    palette_pixel = `OSD_COLOR_1;
            2'd2:    palette_pixel = `OSD_COLOR_2;
            default: palette_pixel = `OSD_COLOR_3;
        endcase
    end

    // Overlay stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pixel_out <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de_out    <= 1'b0;
        end else begin
            pixel_out <= osd_enable_i ? palette_pixel : pixel_i;
            hsync_out <= hsync_i;
            vsync_out <= vsync_i;
            de_out    <= de_i;
        end
    end

    // Transmit stage, rising edge launch
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            tx_r_o     <= '0;
            tx_g_o     <= '0;
            tx_b_o     <= '0;
            tx_hsync_o <= 1'b0;
            tx_vsync_o <= 1'b0;
            tx_de_o    <= 1'b0;
        end else begin
            tx_r_o     <= {pixel_out[23:17], pixel_out[16] & ~`TX_R0_MASK};
            tx_g_o     <= pixel_out[15:8];
            tx_b_o     <= pixel_out[7:0];
            tx_hsync_o <= hsync_out;
            tx_vsync_o <= vsync_out;
            tx_de_o    <= de_out;
        end
    end

    a_r0_masked: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        `TX_R0_MASK |-> (tx_r_o[0] == 1'b0)
    );

endmodule

`default_nettype wire

//--- source/scan_io_top.sv
// Scan converter I/O top level

`timescale 1ns/10ps
`default_nettype none

module scan_io_top import scan_pkg::*; (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic       ctrl_wr_i,
    input  sys_ctrl_t  ctrl_wdata_i,
    input  btn_t       btn_i,
    input  logic       ir_rx_i,
    input  logic       resync_strobe_i,
    input  pixel_t     isl_pixel_i,
    input  logic       isl_hsync_i,
    input  logic       isl_vsync_i,
    input  logic       isl_de_i,
    input  pixel_t     hdmirx_pixel_i,
    input  logic       hdmirx_hsync_i,
    input  logic       hdmirx_vsync_i,
    input  logic       hdmirx_de_i,
    input  logic       osd_enable_i,
    input  osd_color_t osd_color_i,
    output logic       isl_reset_n_o,
    output logic       hdmirx_reset_n_o,
    output led_t       led_o,
    output status_t    status_o,
    output color_t     hdmitx_r_o,
    output color_t     hdmitx_g_o,
    output color_t     hdmitx_b_o,
    output logic       hdmitx_hsync_o,
    output logic       hdmitx_vsync_o,
    output logic       hdmitx_de_o
);

    logic   sys_poweron;
    logic   capture_sel;
    logic   framelock;
    logic   led_active;
    btn_t   btn_sync;
    logic   ir_sync;
    logic   resync_sync;
    pixel_t capt_pixel;
    logic   capt_hsync;
    logic   capt_vsync;
    logic   capt_de;

    sys_ctrl_regs u_sys_ctrl_regs (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .ctrl_wr_i        (ctrl_wr_i),
        .ctrl_wdata_i     (ctrl_wdata_i),
        .btn_sync_i       (btn_sync),
        .ir_sync_i        (ir_sync),
        .led_active_i     (led_active),
        .sys_poweron_o    (sys_poweron),
        .isl_reset_n_o    (isl_reset_n_o),
        .hdmirx_reset_n_o (hdmirx_reset_n_o),
        .capture_sel_o    (capture_sel),
        .framelock_o      (framelock),
        .status_o         (status_o)
    );

    input_sync u_input_sync (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .btn_i           (btn_i),
        .ir_rx_i         (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .btn_sync_o      (btn_sync),
        .ir_sync_o       (ir_sync),
        .resync_sync_o   (resync_sync)
    );

    status_led u_status_led (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .sys_poweron_i (sys_poweron),
        .framelock_i   (framelock),
        .ir_sync_i     (ir_sync),
        .resync_sync_i (resync_sync),
        .led_o         (led_o),
        .led_active_o  (led_active)
    );

    capture_mux u_capture_mux (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel),
        .isl_pixel_i    (isl_pixel_i),
        .hdmirx_pixel_i (hdmirx_pixel_i),
        .isl_hsync_i    (isl_hsync_i),
        .isl_vsync_i    (isl_vsync_i),
        .isl_de_i       (isl_de_i),
        .hdmirx_hsync_i (hdmirx_hsync_i),
        .hdmirx_vsync_i (hdmirx_vsync_i),
        .hdmirx_de_i    (hdmirx_de_i),
        .capt_pixel_o   (capt_pixel),
        .capt_hsync_o   (capt_hsync),
        .capt_vsync_o   (capt_vsync),
        .capt_de_o      (capt_de)
    );

    osd_output u_osd_output (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pixel_i      (capt_pixel),
        .hsync_i      (capt_hsync),
        .vsync_i      (capt_vsync),
        .de_i         (capt_de),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .tx_r_o       (hdmitx_r_o),
        .tx_g_o       (hdmitx_g_o),
        .tx_b_o       (hdmitx_b_o),
        .tx_hsync_o   (hdmitx_hsync_o),
        .tx_vsync_o   (hdmitx_vsync_o),
        .tx_de_o      (hdmitx_de_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_scan_io.sv
// Scan converter I/O testbench

`timescale 1ns/10ps
`default_nettype none

module tb_scan_io import scan_pkg::*; ();

    logic       pclk_out;
    logic       po_reset_n;
    logic       ctrl_wr;
    sys_ctrl_t  ctrl_wdata;
    btn_t       btn;
    logic       ir_rx;
    logic       resync_strobe;
    pixel_t     isl_pixel;
    logic       isl_hsync;
    logic       isl_vsync;
    logic       isl_de;
    pixel_t     hdmirx_pixel;
    logic       hdmirx_hsync;
    logic       hdmirx_vsync;
    logic       hdmirx_de;
    logic       osd_enable;
    osd_color_t osd_color;
    logic       isl_reset_n;
    logic       hdmirx_reset_n;
    led_t       led;
    status_t    status;
    color_t     tx_r;
    color_t     tx_g;
    color_t     tx_b;
    logic       tx_hsync;
    logic       tx_vsync;
    logic       tx_de;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          timeout_count;

    // Reference model state
    sys_ctrl_t   m_ctrl;
    btn_t        m_btn_meta;
    btn_t        m_btn_sync;
    logic        m_ir_meta;
    logic        m_ir_sync;
    logic        m_rs_meta;
    logic        m_rs_sync;
    logic        m_rs_prev;
    logic [7:0]  m_ctr;
    status_t     m_status;
    pixel_t      m_capt_pix;
    logic [2:0]  m_capt_sync;
    pixel_t      m_ovl_pix;
    logic [2:0]  m_ovl_sync;
    pixel_t      m_tx_pix;
    logic [2:0]  m_tx_sync;

    scan_io_top uut (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .ctrl_wr_i        (ctrl_wr),
        .ctrl_wdata_i     (ctrl_wdata),
        .btn_i            (btn),
        .ir_rx_i          (ir_rx),
        .resync_strobe_i  (resync_strobe),
        .isl_pixel_i      (isl_pixel),
        .isl_hsync_i      (isl_hsync),
        .isl_vsync_i      (isl_vsync),
        .isl_de_i         (isl_de),
        .hdmirx_pixel_i   (hdmirx_pixel),
        .hdmirx_hsync_i   (hdmirx_hsync),
        .hdmirx_vsync_i   (hdmirx_vsync),
        .hdmirx_de_i      (hdmirx_de),
        .osd_enable_i     (osd_enable),
        .osd_color_i      (osd_color),
        .isl_reset_n_o    (isl_reset_n),
        .hdmirx_reset_n_o (hdmirx_reset_n),
        .led_o            (led),
        .status_o         (status),
        .hdmitx_r_o       (tx_r),
        .hdmitx_g_o       (tx_g),
        .hdmitx_b_o       (tx_b),
        .hdmitx_hsync_o   (tx_hsync),
        .hdmitx_vsync_o   (tx_vsync),
        .hdmitx_de_o      (tx_de)
    );

    always #50 pclk_out = ~pclk_out;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Black, blue, yellow, white
    function automatic pixel_t palette_entry(input osd_color_t c);
        case (c)
            2'd0:    return 24'h000000;
            2'd1:    return 24'h0000ff;
            2'd2:    return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    function automatic led_t expected_led();
        if (m_ctrl[0]) begin
            return {m_ctrl[14], ~m_ir_sync, (m_ctr != 8'd0)};
        end
        return {2'b00, ~m_ctr[7]};
    endfunction

    task automatic check_pixel(input string name, input color_t got, input color_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic model_reset();
        m_ctrl      = '0;
        m_btn_meta  = '1;
        m_btn_sync  = '1;
        m_ir_meta   = 1'b1;
        m_ir_sync   = 1'b1;
        m_rs_meta   = 1'b0;
        m_rs_sync   = 1'b0;
        m_rs_prev   = 1'b0;
        m_ctr       = '0;
        m_status    = 16'h007f;
        m_capt_pix  = '0;
        m_capt_sync = '0;
        m_ovl_pix   = '0;
        m_ovl_sync  = '0;
        m_tx_pix    = '0;
        m_tx_sync   = '0;
    endtask

    // One clock edge, later stages first so each reads its pre-edge input
    task automatic model_step();
        m_tx_pix  = {m_ovl_pix[23:17], 1'b0, m_ovl_pix[15:0]};
        m_tx_sync = m_ovl_sync;
        m_ovl_pix  = osd_enable ? palette_entry(osd_color) : m_capt_pix;
        m_ovl_sync = m_capt_sync;
        if (m_ctrl[7]) begin
            m_capt_pix  = hdmirx_pixel;
            m_capt_sync = {hdmirx_hsync, hdmirx_vsync, hdmirx_de};
        end else begin
            m_capt_pix  = isl_pixel;
            m_capt_sync = {isl_hsync, isl_vsync, isl_de};
        end
        m_status = {m_ctrl[7:0], (m_ctr != 8'd0), m_ir_sync, m_btn_sync};
        if (!m_ctrl[0]) begin
            m_ctr = m_ctr - 8'd1;
        end else if (m_rs_sync && !m_rs_prev) begin
            m_ctr = 8'hff;
        end else if (m_ctr != 8'd0) begin
            m_ctr = m_ctr - 8'd1;
        end
        m_rs_prev  = m_rs_sync;
        m_btn_sync = m_btn_meta;
        m_btn_meta = btn;
        m_ir_sync  = m_ir_meta;
        m_ir_meta  = ir_rx;
        m_rs_sync  = m_rs_meta;
        m_rs_meta  = resync_strobe;
        if (ctrl_wr) begin
            m_ctrl = ctrl_wdata;
        end
    endtask

    task automatic check_all();
        check_bit("isl_reset_n_o", isl_reset_n, m_ctrl[1]);
        check_bit("hdmirx_reset_n_o", hdmirx_reset_n, m_ctrl[2]);
        check_led("led_o", led, expected_led());
        check_status("status_o", status, m_status);
        check_pixel("hdmitx_r_o", tx_r, m_tx_pix[23:16]);
        check_pixel("hdmitx_g_o", tx_g, m_tx_pix[15:8]);
        check_pixel("hdmitx_b_o", tx_b, m_tx_pix[7:0]);
        check_bit("hdmitx_hsync_o", tx_hsync, m_tx_sync[2]);
        check_bit("hdmitx_vsync_o", tx_vsync, m_tx_sync[1]);
        check_bit("hdmitx_de_o", tx_de, m_tx_sync[0]);
    endtask

    // Outputs are settled 1 ns after the edge, inputs change right after
    task automatic next_cycle();
        @(posedge pclk_out);
        #1;
        if (!po_reset_n) begin
            model_reset();
        end else begin
            model_step();
        end
        check_all();
    endtask

    task automatic drive_random(input logic osd_on);
        logic [31:0] r;
        r = rand_bits(24);
        isl_pixel = r[23:0];
        r = rand_bits(24);
        hdmirx_pixel = r[23:0];
        r = rand_bits(6);
        {isl_hsync, isl_vsync, isl_de, hdmirx_hsync, hdmirx_vsync, hdmirx_de} = r[5:0];
        r = rand_bits(3);
        osd_enable = osd_on & r[0];
        osd_color  = r[2:1];
        r = rand_bits(4);
        ctrl_wr = (r[3:0] == 4'd0);
        r = rand_bits(16);
        ctrl_wdata = r[15:0];
        r = rand_bits(7);
        btn   = r[5:0];
        ir_rx = r[6];
        r = rand_bits(4);
        resync_strobe = (r[3:0] == 4'd0);
    endtask

    task automatic write_ctrl(input sys_ctrl_t word);
        drive_random(1'b0);
        resync_strobe = 1'b0;
        ctrl_wr       = 1'b1;
        ctrl_wdata    = word;
        next_cycle();
    endtask

    task automatic wait_led0(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (led[0] !== level && n < limit) begin
            drive_random(1'b0);
            ctrl_wr       = 1'b0;
            resync_strobe = 1'b0;
            next_cycle();
            n++;
        end
        if (led[0] !== level) begin
            $display("Timeout after %0d cycles waiting for %s", limit, what);
            timeout_count++;
        end
    endtask

    initial begin
        logic level;
        pclk_out      = 1'b0;
        po_reset_n    = 1'b0;
        ctrl_wr       = 1'b0;
        ctrl_wdata    = '0;
        btn           = '1;
        ir_rx         = 1'b1;
        resync_strobe = 1'b0;
        isl_pixel     = '0;
        isl_hsync     = 1'b0;
        isl_vsync     = 1'b0;
        isl_de        = 1'b0;
        hdmirx_pixel  = '0;
        hdmirx_hsync  = 1'b0;
        hdmirx_vsync  = 1'b0;
        hdmirx_de     = 1'b0;
        osd_enable    = 1'b0;
        osd_color     = '0;
        lfsr_state    = 32'hff56;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        model_reset();

        repeat (4) next_cycle();
        po_reset_n = 1'b1;
        check_status("status_o after reset", status, 16'h007f);
        check_led("led_o after reset", led, 3'b001);
        check_pixel("hdmitx_r_o after reset", tx_r, 8'h00);

        // Random video with OSD off, forced source switches
        for (int i = 0; i < 300; i++) begin
            drive_random(1'b0);
            if (i == 100) begin
                ctrl_wr    = 1'b1;
                ctrl_wdata = 16'h0087;
            end else if (i == 200) begin
                ctrl_wr    = 1'b1;
                ctrl_wdata = 16'h0007;
            end
            next_cycle();
        end

        // OSD overlay active
        for (int i = 0; i < 300; i++) begin
            drive_random(1'b1);
            next_cycle();
        end

        // Resync stretch with power on and framelock set
        write_ctrl(16'h4007);
        wait_led0(1'b0, 300, "the stretch counter to drain");
        drive_random(1'b0);
        ctrl_wr       = 1'b0;
        resync_strobe = 1'b1;
        next_cycle();
        wait_led0(1'b1, 10, "LED bit 0 to rise after a resync pulse");
        wait_led0(1'b0, 300, "LED bit 0 to fall after the counter drains");

        // Standby blink
        write_ctrl(16'h0006);
        level = led[0];
        wait_led0(~level, 300, "LED bit 0 to toggle with power off");
        wait_led0(level, 300, "LED bit 0 to toggle back with power off");

        $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/scan_pkg.sv
source/sys_ctrl_regs.sv
source/input_sync.sv
source/status_led.sv
video/capture_mux.sv
video/osd_output.sv
source/scan_io_top.sv
tests/tb_scan_io.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_scan_io
FILELIST  = tb.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)
